/* dma_csr_pkg.sv */
// Shared widths, register indices and version constant for the DMA CSR block
package dma_csr_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    typedef logic [6:0]  csr_addr_t;      // Register index
    typedef logic [31:0] csr_data_t;
    typedef logic [31:0] dma_addr_t;
    typedef logic [15:0] dma_len_t;       // Length in DWORDs
    typedef logic [2:0]  tlp_tc_t;
    typedef logic [7:0]  up_addr_t;       // Upper address byte for 64-bit TLPs
    typedef logic [31:0] pkt_count_t;
    typedef logic [31:0] perf_cnt_t;
    typedef logic [20:0] cpld_size_t;     // Up to 2M DWORDs
    typedef logic [5:0]  lnk_width_t;
    typedef logic [2:0]  payload_size_t;  // Encoded as in the PCIe device control reg

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam csr_addr_t REG_CTRL_ID      = 7'd0;
    localparam csr_addr_t REG_DMA_CTRL     = 7'd1;
    localparam csr_addr_t REG_MWR_ADDR     = 7'd2;
    localparam csr_addr_t REG_MWR_LEN      = 7'd3;
    localparam csr_addr_t REG_MWR_COUNT    = 7'd4;
    localparam csr_addr_t REG_MWR_DATA     = 7'd5;
    localparam csr_addr_t REG_CPLD_DATA    = 7'd6;
    localparam csr_addr_t REG_MRD_ADDR     = 7'd7;
    localparam csr_addr_t REG_MRD_LEN      = 7'd8;
    localparam csr_addr_t REG_MRD_COUNT    = 7'd9;
    localparam csr_addr_t REG_MWR_PERF     = 7'd10;  // Read only from here on
    localparam csr_addr_t REG_MRD_PERF     = 7'd11;
    localparam csr_addr_t REG_CPL_STATUS   = 7'd12;
    localparam csr_addr_t REG_CPLD_FOUND   = 7'd13;
    localparam csr_addr_t REG_CPLD_SIZE    = 7'd14;
    localparam csr_addr_t REG_LINK_WIDTH   = 7'd15;
    localparam csr_addr_t REG_LINK_PAYLOAD = 7'd16;

    localparam logic [7:0] VERSION_NUMBER  = 8'h16;

endpackage

/* dma_csr_ctrl.sv */
// Write decoder and writable DMA setup registers
`timescale 1ns/1ps

module dma_csr_ctrl import dma_csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  csr_addr_t  csr_addr_i,
    input  logic       csr_wr_en_i,
    input  csr_data_t  csr_wr_data_i,
    output logic       init_rst_o,
    output logic       mwr_start_o,
    output logic       mwr_int_dis_o,
    output logic       mwr_relaxed_order_o,
    output logic       mwr_nosnoop_o,
    output logic       mrd_start_o,
    output logic       mrd_int_dis_o,
    output logic       mrd_relaxed_order_o,
    output logic       mrd_nosnoop_o,
    output dma_addr_t  mwr_addr_o,
    output dma_addr_t  mrd_addr_o,
    output dma_len_t   mwr_len_o,
    output dma_len_t   mrd_len_o,
    output tlp_tc_t    mwr_tlp_tc_o,
    output tlp_tc_t    mrd_tlp_tc_o,
    output logic       mwr_64b_en_o,
    output logic       mrd_64b_en_o,
    output logic       mwr_phant_func_dis1_o,
    output logic       mrd_phant_func_dis1_o,
    output up_addr_t   mwr_up_addr_o,
    output up_addr_t   mrd_up_addr_o,
    output pkt_count_t mwr_count_o,
    output pkt_count_t mrd_count_o,
    output csr_data_t  mwr_data_o,
    output csr_data_t  cpld_data_o
);

    // --------------------------------------------------
    // Control bits, regs 0 and 1
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o          <= 1'b0;
            mwr_start_o         <= 1'b0;
            mwr_int_dis_o       <= 1'b0;
            mwr_relaxed_order_o <= 1'b0;
            mwr_nosnoop_o       <= 1'b0;
            mrd_start_o         <= 1'b0;
            mrd_int_dis_o       <= 1'b0;
            mrd_relaxed_order_o <= 1'b0;
            mrd_nosnoop_o       <= 1'b0;
        end else begin
            if (csr_wr_en_i && csr_addr_i == REG_CTRL_ID)
                init_rst_o <= csr_wr_data_i[0];
            if (csr_wr_en_i && csr_addr_i == REG_DMA_CTRL) begin
                mwr_start_o         <= csr_wr_data_i[0];
                mwr_relaxed_order_o <= csr_wr_data_i[5];
                mwr_nosnoop_o       <= csr_wr_data_i[6];
                mwr_int_dis_o       <= csr_wr_data_i[7];
                mrd_start_o         <= csr_wr_data_i[16];
                mrd_relaxed_order_o <= csr_wr_data_i[21];
                mrd_nosnoop_o       <= csr_wr_data_i[22];
                mrd_int_dis_o       <= csr_wr_data_i[23];
            end
            // Initiator reset wins over any start write
            if (init_rst_o) begin
                mwr_start_o <= 1'b0;
                mrd_start_o <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Addresses, lengths, counts and data words
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (csr_wr_en_i) begin
            case (csr_addr_i)
                REG_MWR_ADDR:  mwr_addr_o <= csr_wr_data_i;
                REG_MWR_LEN: begin
                    mwr_len_o             <= csr_wr_data_i[15:0];
                    mwr_tlp_tc_o          <= csr_wr_data_i[18:16];
                    mwr_64b_en_o          <= csr_wr_data_i[19];
                    mwr_phant_func_dis1_o <= csr_wr_data_i[20];
                    mwr_up_addr_o         <= csr_wr_data_i[31:24];
                end
                REG_MWR_COUNT: mwr_count_o <= csr_wr_data_i;
                REG_MWR_DATA:  mwr_data_o  <= csr_wr_data_i;  // Write pattern
                REG_CPLD_DATA: cpld_data_o <= csr_wr_data_i;  // Expected completion data
                REG_MRD_ADDR:  mrd_addr_o  <= csr_wr_data_i;
                REG_MRD_LEN: begin
                    mrd_len_o             <= csr_wr_data_i[15:0];
                    mrd_tlp_tc_o          <= csr_wr_data_i[18:16];
                    mrd_64b_en_o          <= csr_wr_data_i[19];
                    mrd_phant_func_dis1_o <= csr_wr_data_i[20];
                    mrd_up_addr_o         <= csr_wr_data_i[31:24];
                end
                REG_MRD_COUNT: mrd_count_o <= csr_wr_data_i;
                default: ;
            endcase
        end
    end

    // Starts stay off while the initiator is held in reset
    a_init_clears_start: assert property (@(posedge clk) disable iff (!rst_n)
        init_rst_o |=> !mwr_start_o && !mrd_start_o);

endmodule

/* dma_perf_monitor.sv */
// Memory write and memory read performance cycle counters
`timescale 1ns/1ps

module dma_perf_monitor import dma_csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_rst_i,
    input  logic      mwr_start_i,
    input  logic      mwr_done_i,
    input  logic      mrd_start_i,
    input  logic      mrd_done_i,
    output perf_cnt_t mwr_perf_o,
    output perf_cnt_t mrd_perf_o
);

    // Count cycles between start and done
    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            mwr_perf_o <= '0;
            mrd_perf_o <= '0;
        end else begin
            if (mwr_start_i && !mwr_done_i)
                mwr_perf_o <= mwr_perf_o + 1'b1;
            if (mrd_start_i && !mrd_done_i)
                mrd_perf_o <= mrd_perf_o + 1'b1;
        end
    end

    a_mwr_perf_mono: assert property (@(posedge clk) disable iff (!rst_n)
        !init_rst_i |=> mwr_perf_o >= $past(mwr_perf_o));

    a_mrd_perf_mono: assert property (@(posedge clk) disable iff (!rst_n)
        !init_rst_i |=> mrd_perf_o >= $past(mrd_perf_o));

endmodule

/* dma_cpld_tracker.sv */
// Expected completion size, size compare and memory read done flag
`timescale 1ns/1ps

module dma_cpld_tracker import dma_csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_rst_i,
    input  logic       mrd_start_i,
    input  dma_len_t   mrd_len_i,
    input  pkt_count_t mrd_count_i,
    input  csr_data_t  cpld_data_size_i,
    output logic       mrd_done_o
);

    cpld_size_t expect_size;
    cpld_size_t rcvd_size;
    logic       size_match;

    // --------------------------------------------------
    // Two stage compare pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            expect_size <= '0;
            rcvd_size   <= '0;
            size_match  <= 1'b0;
        end else begin
            // Length times count, truncated to the size counter width
            expect_size <= {5'b0, mrd_len_i} * {5'b0, mrd_count_i[15:0]};
            rcvd_size   <= cpld_data_size_i[20:0];
            size_match  <= (expect_size == rcvd_size);
        end
    end

    // Sticky until the next initiator reset
    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i)
            mrd_done_o <= 1'b0;
        else if (mrd_start_i && size_match)
            mrd_done_o <= 1'b1;
    end

    a_done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mrd_done_o) |-> $past(mrd_start_i));

endmodule

/* dma_csr_readback.sv */
// Registered read multiplexer for all CSR words
`timescale 1ns/1ps

module dma_csr_readback import dma_csr_pkg::*; #(
    parameter logic [7:0] FPGA_FAMILY    = 8'h23,
    parameter logic [3:0] INTERFACE_TYPE = 4'h1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  csr_addr_t     csr_addr_i,
    input  logic          init_rst_i,
    input  logic          mwr_start_i,
    input  logic          mwr_int_dis_i,
    input  logic          mwr_relaxed_order_i,
    input  logic          mwr_nosnoop_i,
    input  logic          mrd_start_i,
    input  logic          mrd_int_dis_i,
    input  logic          mrd_relaxed_order_i,
    input  logic          mrd_nosnoop_i,
    input  dma_addr_t     mwr_addr_i,
    input  dma_addr_t     mrd_addr_i,
    input  dma_len_t      mwr_len_i,
    input  dma_len_t      mrd_len_i,
    input  tlp_tc_t       mwr_tlp_tc_i,
    input  tlp_tc_t       mrd_tlp_tc_i,
    input  logic          mwr_64b_en_i,
    input  logic          mrd_64b_en_i,
    input  logic          mwr_phant_func_dis1_i,
    input  logic          mrd_phant_func_dis1_i,
    input  up_addr_t      mwr_up_addr_i,
    input  up_addr_t      mrd_up_addr_i,
    input  pkt_count_t    mwr_count_i,
    input  pkt_count_t    mrd_count_i,
    input  csr_data_t     mwr_data_i,
    input  csr_data_t     cpld_data_i,
    input  logic          mrd_done_i,
    input  perf_cnt_t     mwr_perf_i,
    input  perf_cnt_t     mrd_perf_i,
    input  logic          cpld_data_err_i,
    input  logic          cpld_malformed_i,
    input  logic [7:0]    cpl_ur_found_i,
    input  logic [7:0]    cpl_ur_tag_i,
    input  csr_data_t     cpld_found_i,
    input  csr_data_t     cpld_data_size_i,
    input  lnk_width_t    cfg_cap_max_lnk_width_i,
    input  lnk_width_t    cfg_neg_max_lnk_width_i,
    input  payload_size_t cfg_cap_max_payload_size_i,
    input  payload_size_t cfg_prg_max_payload_size_i,
    input  payload_size_t cfg_max_rd_req_size_i,
    output csr_data_t     csr_rd_data_o
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_rd_data_o <= '0;
        end else begin
            case (csr_addr_i)
                REG_CTRL_ID: csr_rd_data_o <= {FPGA_FAMILY, 4'b0, INTERFACE_TYPE,
                                               VERSION_NUMBER, 7'b0, init_rst_i};
                REG_DMA_CTRL: csr_rd_data_o <= {cpld_data_err_i, 6'b0, mrd_done_i,
                    mrd_int_dis_i, mrd_nosnoop_i, mrd_relaxed_order_i, 4'b0, mrd_start_i,
                    8'b0,
                    mwr_int_dis_i, mwr_nosnoop_i, mwr_relaxed_order_i, 4'b0, mwr_start_i};
                REG_MWR_ADDR:  csr_rd_data_o <= mwr_addr_i;
                REG_MWR_LEN:   csr_rd_data_o <= {mwr_up_addr_i, 3'b0, mwr_phant_func_dis1_i,
                                                 mwr_64b_en_i, mwr_tlp_tc_i, mwr_len_i};
                REG_MWR_COUNT: csr_rd_data_o <= mwr_count_i;
                REG_MWR_DATA:  csr_rd_data_o <= mwr_data_i;
                REG_CPLD_DATA: csr_rd_data_o <= cpld_data_i;
                REG_MRD_ADDR:  csr_rd_data_o <= mrd_addr_i;
                REG_MRD_LEN:   csr_rd_data_o <= {mrd_up_addr_i, 3'b0, mrd_phant_func_dis1_i,
                                                 mrd_64b_en_i, mrd_tlp_tc_i, mrd_len_i};
                REG_MRD_COUNT: csr_rd_data_o <= mrd_count_i;
                // Read-only status from here on
                REG_MWR_PERF:   csr_rd_data_o <= mwr_perf_i;
                REG_MRD_PERF:   csr_rd_data_o <= mrd_perf_i;
                REG_CPL_STATUS: csr_rd_data_o <= {15'b0, cpld_malformed_i,
                                                  cpl_ur_tag_i, cpl_ur_found_i};
                REG_CPLD_FOUND: csr_rd_data_o <= cpld_found_i;
                REG_CPLD_SIZE:  csr_rd_data_o <= cpld_data_size_i;
                REG_LINK_WIDTH: csr_rd_data_o <= {16'b0, 2'b0, cfg_neg_max_lnk_width_i,
                                                  2'b0, cfg_cap_max_lnk_width_i};
                REG_LINK_PAYLOAD: csr_rd_data_o <= {13'b0, cfg_max_rd_req_size_i,
                                                    5'b0, cfg_prg_max_payload_size_i,
                                                    5'b0, cfg_cap_max_payload_size_i};
                default: csr_rd_data_o <= '0;  // Unmapped space
            endcase
        end
    end

endmodule

/* dma_csr_top.sv */
// Top level of the DMA CSR block with control, counters, tracker and readback
`timescale 1ns/1ps

module dma_csr_top import dma_csr_pkg::*; #(
    parameter logic [7:0] FPGA_FAMILY    = 8'h23,
    parameter logic [3:0] INTERFACE_TYPE = 4'h1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  csr_addr_t     csr_addr_i,
    input  logic          csr_wr_en_i,
    input  csr_data_t     csr_wr_data_i,
    output csr_data_t     csr_rd_data_o,
    output logic          init_rst_o,
    output logic          mwr_start_o,
    output logic          mwr_int_dis_o,
    output logic          mwr_relaxed_order_o,
    output logic          mwr_nosnoop_o,
    output logic          mrd_start_o,
    output logic          mrd_int_dis_o,
    output logic          mrd_relaxed_order_o,
    output logic          mrd_nosnoop_o,
    output dma_addr_t     mwr_addr_o,
    output dma_addr_t     mrd_addr_o,
    output dma_len_t      mwr_len_o,
    output dma_len_t      mrd_len_o,
    output tlp_tc_t       mwr_tlp_tc_o,
    output tlp_tc_t       mrd_tlp_tc_o,
    output logic          mwr_64b_en_o,
    output logic          mrd_64b_en_o,
    output logic          mwr_phant_func_dis1_o,
    output logic          mrd_phant_func_dis1_o,
    output up_addr_t      mwr_up_addr_o,
    output up_addr_t      mrd_up_addr_o,
    output pkt_count_t    mwr_count_o,
    output pkt_count_t    mrd_count_o,
    output csr_data_t     mwr_data_o,
    output csr_data_t     cpld_data_o,
    input  logic          mwr_done_i,
    output logic          mrd_done_o,
    input  logic          cpld_data_err_i,
    input  logic          cpld_malformed_i,
    input  logic [7:0]    cpl_ur_found_i,
    input  logic [7:0]    cpl_ur_tag_i,
    input  csr_data_t     cpld_found_i,
    input  csr_data_t     cpld_data_size_i,
    input  lnk_width_t    cfg_cap_max_lnk_width_i,
    input  lnk_width_t    cfg_neg_max_lnk_width_i,
    input  payload_size_t cfg_cap_max_payload_size_i,
    input  payload_size_t cfg_prg_max_payload_size_i,
    input  payload_size_t cfg_max_rd_req_size_i
);

    perf_cnt_t mwr_perf;
    perf_cnt_t mrd_perf;

    dma_csr_ctrl i_ctrl (.*);

    dma_perf_monitor i_perf (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_rst_i  (init_rst_o),
        .mwr_start_i (mwr_start_o),
        .mwr_done_i  (mwr_done_i),
        .mrd_start_i (mrd_start_o),
        .mrd_done_i  (mrd_done_o),   // Read done comes from the tracker
        .mwr_perf_o  (mwr_perf),
        .mrd_perf_o  (mrd_perf)
    );

    dma_cpld_tracker i_cpld (
        .clk              (clk),
        .rst_n            (rst_n),
        .init_rst_i       (init_rst_o),
        .mrd_start_i      (mrd_start_o),
        .mrd_len_i        (mrd_len_o),
        .mrd_count_i      (mrd_count_o),
        .cpld_data_size_i (cpld_data_size_i),
        .mrd_done_o       (mrd_done_o)
    );

    // --------------------------------------------------
    // Read mux
    // --------------------------------------------------
    dma_csr_readback #(
        .FPGA_FAMILY    (FPGA_FAMILY),
        .INTERFACE_TYPE (INTERFACE_TYPE)
    ) i_rdbk (
        .init_rst_i            (init_rst_o),
        .mwr_start_i           (mwr_start_o),
        .mwr_int_dis_i         (mwr_int_dis_o),
        .mwr_relaxed_order_i   (mwr_relaxed_order_o),
        .mwr_nosnoop_i         (mwr_nosnoop_o),
        .mrd_start_i           (mrd_start_o),
        .mrd_int_dis_i         (mrd_int_dis_o),
        .mrd_relaxed_order_i   (mrd_relaxed_order_o),
        .mrd_nosnoop_i         (mrd_nosnoop_o),
        .mwr_addr_i            (mwr_addr_o),
        .mrd_addr_i            (mrd_addr_o),
        .mwr_len_i             (mwr_len_o),
        .mrd_len_i             (mrd_len_o),
        .mwr_tlp_tc_i          (mwr_tlp_tc_o),
        .mrd_tlp_tc_i          (mrd_tlp_tc_o),
        .mwr_64b_en_i          (mwr_64b_en_o),
        .mrd_64b_en_i          (mrd_64b_en_o),
        .mwr_phant_func_dis1_i (mwr_phant_func_dis1_o),
        .mrd_phant_func_dis1_i (mrd_phant_func_dis1_o),
        .mwr_up_addr_i         (mwr_up_addr_o),
        .mrd_up_addr_i         (mrd_up_addr_o),
        .mwr_count_i           (mwr_count_o),
        .mrd_count_i           (mrd_count_o),
        .mwr_data_i            (mwr_data_o),
        .cpld_data_i           (cpld_data_o),
        .mrd_done_i            (mrd_done_o),
        .mwr_perf_i            (mwr_perf),
        .mrd_perf_i            (mrd_perf),
        .*
    );

endmodule

/* tb_dma_csr.sv */
// Testbench for the DMA CSR block with register model, assertions and watchdog
`timescale 1ns/1ps

module tb_dma_csr import dma_csr_pkg::*; ();

    localparam logic [7:0] FAMILY   = 8'h23;
    localparam logic [3:0] IF_TYPE  = 4'h1;
    localparam int WATCHDOG_CYCLES  = 2000;          // Full sequence is under 500 cycles
    localparam csr_data_t REG1_MASK = 32'h00E1_00E1; // Writable bits of reg 1
    localparam csr_data_t LEN_MASK  = 32'hFF1F_FFFF; // Writable bits of regs 3 and 8

    logic          clk, rst_n, csr_wr_en_i;
    csr_addr_t     csr_addr_i;
    csr_data_t     csr_wr_data_i, csr_rd_data_o;
    logic          init_rst_o, mwr_start_o, mwr_int_dis_o, mwr_relaxed_order_o, mwr_nosnoop_o;
    logic          mrd_start_o, mrd_int_dis_o, mrd_relaxed_order_o, mrd_nosnoop_o;
    dma_addr_t     mwr_addr_o, mrd_addr_o;
    dma_len_t      mwr_len_o, mrd_len_o;
    tlp_tc_t       mwr_tlp_tc_o, mrd_tlp_tc_o;
    logic          mwr_64b_en_o, mrd_64b_en_o, mwr_phant_func_dis1_o, mrd_phant_func_dis1_o;
    up_addr_t      mwr_up_addr_o, mrd_up_addr_o;
    pkt_count_t    mwr_count_o, mrd_count_o;
    csr_data_t     mwr_data_o, cpld_data_o, cpld_found_i, cpld_data_size_i;
    logic          mwr_done_i, mrd_done_o, cpld_data_err_i, cpld_malformed_i;
    logic [7:0]    cpl_ur_found_i, cpl_ur_tag_i;
    lnk_width_t    cfg_cap_max_lnk_width_i, cfg_neg_max_lnk_width_i;
    payload_size_t cfg_cap_max_payload_size_i, cfg_prg_max_payload_size_i;
    payload_size_t cfg_max_rd_req_size_i;

    int           seed = 92063;
    csr_data_t    m_reg [0:9];        // Modelled words of the writable regs
    logic         m_done;
    perf_cnt_t    mwr_cyc, mrd_cyc;   // Cycles counted at the ports
    int           match_cyc, rd_errs, port_errs, ctrl_errs;
    logic         rd_chk, setup_chk, idle_chk, size_wait, match_wait;
    csr_data_t    rd_exp;
    string        chk_name;
    logic [261:0] setup_exp, setup_act;

    dma_csr_top #(.FPGA_FAMILY(FAMILY), .INTERFACE_TYPE(IF_TYPE)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    assign setup_exp = {m_reg[2], m_reg[3], m_reg[4], m_reg[5], m_reg[6], m_reg[7], m_reg[8],
                        m_reg[9], m_reg[1][23:21], m_reg[1][7:5]};
    assign setup_act = {mwr_addr_o,
        mwr_up_addr_o, 3'b0, mwr_phant_func_dis1_o, mwr_64b_en_o, mwr_tlp_tc_o, mwr_len_o,
        mwr_count_o, mwr_data_o, cpld_data_o, mrd_addr_o,
        mrd_up_addr_o, 3'b0, mrd_phant_func_dis1_o, mrd_64b_en_o, mrd_tlp_tc_o, mrd_len_o,
        mrd_count_o, mrd_int_dis_o, mrd_nosnoop_o, mrd_relaxed_order_o,
        mwr_int_dis_o, mwr_nosnoop_o, mwr_relaxed_order_o};

    // Port view of the performance rule, sampled mid cycle
    always @(negedge clk) begin
        if (!rst_n || init_rst_o) begin
            mwr_cyc <= '0;
            mrd_cyc <= '0;
        end else begin
            if (mwr_start_o && !mwr_done_i)
                mwr_cyc <= mwr_cyc + 32'd1;
            if (mrd_start_o && !mrd_done_o)
                mrd_cyc <= mrd_cyc + 32'd1;
        end
        match_cyc <= (match_wait && !mrd_done_o) ? match_cyc + 1 : 0;
    end

    function automatic csr_data_t expected_word(input csr_addr_t addr);
        case (addr)
            REG_CTRL_ID:    return {FAMILY, 4'h0, IF_TYPE, VERSION_NUMBER, 7'b0, m_reg[0][0]};
            REG_DMA_CTRL:   return m_reg[1] | {cpld_data_err_i, 6'b0, m_done, 24'b0};
            REG_MWR_PERF:   return mwr_cyc;
            REG_MRD_PERF:   return mrd_cyc;
            REG_CPL_STATUS: return {15'b0, cpld_malformed_i, cpl_ur_tag_i, cpl_ur_found_i};
            REG_CPLD_FOUND: return cpld_found_i;
            REG_CPLD_SIZE:  return cpld_data_size_i;
            REG_LINK_WIDTH: return {18'b0, cfg_neg_max_lnk_width_i, 2'b0, cfg_cap_max_lnk_width_i};
            REG_LINK_PAYLOAD: return {13'b0, cfg_max_rd_req_size_i, 5'b0,
                                      cfg_prg_max_payload_size_i, 5'b0, cfg_cap_max_payload_size_i};
            default: return (addr <= REG_MRD_COUNT) ? m_reg[addr[3:0]] : '0;
        endcase
    endfunction

    // --------------------------------------------------
    // Bus tasks
    // --------------------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        csr_addr_i    = addr;
        csr_wr_data_i = data;
        csr_wr_en_i   = 1'b1;
        idle_cycles(1);
        csr_wr_en_i   = 1'b0;
        case (addr)
            REG_CTRL_ID: begin
                m_reg[0] = {31'b0, data[0]};
                if (data[0]) begin
                    m_reg[1] = m_reg[1] & ~32'h0001_0001;  // Starts and done dropped
                    m_done   = 1'b0;
                end
            end
            REG_DMA_CTRL: m_reg[1] = data & REG1_MASK;
            REG_MWR_LEN, REG_MRD_LEN: m_reg[addr[3:0]] = data & LEN_MASK;
            default: m_reg[addr[3:0]] = data;
        endcase
    endtask

    task automatic read_check(input csr_addr_t addr, input string name);
        csr_addr_i = addr;
        idle_cycles(1);
        chk_name = name;
        rd_exp   = expected_word(addr);
        rd_chk   = 1'b1;
        idle_cycles(1);
        rd_chk   = 1'b0;
    endtask

    task automatic randomize_status();
        csr_data_t rnd;
        rnd = $random(seed);
        cpld_data_err_i            = rnd[0];
        cpld_malformed_i           = rnd[1];
        cfg_cap_max_payload_size_i = rnd[4:2];
        cfg_prg_max_payload_size_i = rnd[7:5];
        cfg_max_rd_req_size_i      = rnd[10:8];
        cfg_cap_max_lnk_width_i    = rnd[16:11];
        cfg_neg_max_lnk_width_i    = rnd[22:17];
        cpl_ur_found_i             = rnd[30:23];
        rnd = $random(seed);
        cpl_ur_tag_i     = rnd[7:0];
        cpld_found_i     = $random(seed);
        cpld_data_size_i = $random(seed);
    endtask

    task automatic print_counts();
        $display("Errors: readback %0d, setup ports %0d, control %0d",
                 rd_errs, port_errs, ctrl_errs);
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_readback: assert property (@(posedge clk) disable iff (!rst_n)
        rd_chk |-> csr_rd_data_o == rd_exp)
    else begin
        rd_errs++;
        $display("FAIL %s: expected %08h actual %08h", chk_name, $sampled(rd_exp),
                 $sampled(csr_rd_data_o));
    end

    a_setup_ports: assert property (@(posedge clk) disable iff (!rst_n)
        setup_chk |-> setup_act == setup_exp)
    else begin
        port_errs++;
        $display("FAIL setup_ports: expected %h actual %h", $sampled(setup_exp),
                 $sampled(setup_act));
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> !init_rst_o && !mwr_start_o && !mrd_start_o && !mrd_done_o)
    else begin
        ctrl_errs++;
        $display("Init, start or done output is high right after reset");
    end

    a_init_stop: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(init_rst_o) |=> !mwr_start_o && !mrd_start_o && !mrd_done_o)
    else begin
        ctrl_errs++;
        $display("Start or done output still high one cycle after initiator reset");
    end

    a_no_early_done: assert property (@(posedge clk) disable iff (!rst_n)
        size_wait |-> !mrd_done_o)
    else begin
        ctrl_errs++;
        $display("mrd_done_o set while completion size differed from length times count");
    end

    a_done_bound: assert property (@(posedge clk) disable iff (!rst_n)
        match_wait |-> match_cyc <= 8)
    else begin
        ctrl_errs++;
        $display("mrd_done_o did not rise within 8 cycles of a matching completion size");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        print_counts();
        $display("sim failed");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        csr_data_t rnd;
        csr_data_t size_v;
        csr_addr_t addr;
        int        len_v;
        int        cnt_v;
        rst_n = 1'b0;
        csr_addr_i = '0;
        csr_wr_en_i = 1'b0;
        csr_wr_data_i = '0;
        mwr_done_i = 1'b0;
        cpld_data_err_i = 1'b0;
        cpld_malformed_i = 1'b0;
        cpl_ur_found_i = '0;
        cpl_ur_tag_i = '0;
        cpld_found_i = '0;
        cpld_data_size_i = '0;
        cfg_cap_max_lnk_width_i = '0;
        cfg_neg_max_lnk_width_i = '0;
        cfg_cap_max_payload_size_i = '0;
        cfg_prg_max_payload_size_i = '0;
        cfg_max_rd_req_size_i = '0;
        {m_done, rd_chk, setup_chk, idle_chk, size_wait, match_wait} = '0;
        {rd_exp, rd_errs, port_errs, ctrl_errs} = '0;
        for (int r = 0; r <= 9; r++)
            m_reg[r] = '0;
        idle_cycles(3);
        rst_n = 1'b1;

        idle_chk = 1'b1;
        read_check(REG_CTRL_ID, "reset_id");
        idle_chk = 1'b0;

        // Setup registers, starts kept off here
        for (int r = 2; r <= 9; r++)
            write_reg(csr_addr_t'(r), $random(seed));
        write_reg(REG_DMA_CTRL, $random(seed) & ~32'h0001_0001);
        setup_chk = 1'b1;
        for (int r = 1; r <= 9; r++)
            read_check(csr_addr_t'(r), "setup_sweep");
        repeat (20) begin
            rnd  = $random(seed);
            addr = csr_addr_t'(1 + ({$random(seed)} % 9));
            if (addr == REG_DMA_CTRL)
                rnd = rnd & ~32'h0001_0001;
            write_reg(addr, rnd);
            read_check(addr, "setup_random");
        end

        // Initiator reset
        write_reg(REG_DMA_CTRL, m_reg[1] | 32'h0001_0001);
        idle_cycles(4);
        write_reg(REG_CTRL_ID, 32'h1);
        idle_cycles(1);
        read_check(REG_DMA_CTRL, "init_clears_start");
        read_check(REG_MWR_PERF, "init_clears_mwr_perf");
        read_check(REG_MRD_PERF, "init_clears_mrd_perf");
        read_check(REG_CTRL_ID, "init_bit_set");
        write_reg(REG_CTRL_ID, 32'h0);

        // Memory write performance count
        write_reg(REG_DMA_CTRL, m_reg[1] | 32'h1);
        idle_cycles(5 + ({$random(seed)} % 36));
        mwr_done_i = 1'b1;
        idle_cycles(1);
        read_check(REG_MWR_PERF, "mwr_perf");

        // Memory read done on size match
        len_v  = 1 + ({$random(seed)} % 64);
        cnt_v  = 1 + ({$random(seed)} % 16);
        size_v = csr_data_t'(len_v * cnt_v);
        cpld_data_size_i = size_v + csr_data_t'(1 + ({$random(seed)} % 5));
        size_wait = 1'b1;
        rnd = $random(seed);
        write_reg(REG_MRD_LEN, {rnd[31:16], len_v[15:0]});
        write_reg(REG_MRD_COUNT, csr_data_t'(cnt_v));
        idle_cycles(2);  // Compare pipeline takes the new product
        write_reg(REG_DMA_CTRL, m_reg[1] | 32'h0001_0000);
        idle_cycles(4 + ({$random(seed)} % 27));
        size_wait = 1'b0;
        cpld_data_size_i = size_v;
        match_wait = 1'b1;
        while (!mrd_done_o && match_cyc <= 8)
            idle_cycles(1);
        match_wait = 1'b0;
        m_done = 1'b1;
        read_check(REG_DMA_CTRL, "mrd_done_bit");
        read_check(REG_MRD_PERF, "mrd_perf");

        // Read-only status words
        repeat (4) begin
            randomize_status();
            for (int r = 12; r <= 16; r++)
                read_check(csr_addr_t'(r), "status_regs");
            read_check(REG_DMA_CTRL, "data_err_bit");
            rnd = $random(seed);
            read_check({1'b1, rnd[5:0]}, "unmapped_addr");
        end

        print_counts();
        if (rd_errs + port_errs + ctrl_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* files.f */
dma_csr_pkg.sv
dma_csr_ctrl.sv
dma_perf_monitor.sv
dma_cpld_tracker.sv
dma_csr_readback.sv
dma_csr_top.sv
tb_dma_csr.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_dma_csr
FILELIST   := files.f
OBJ_DIR    := obj_dir
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
